// ==== src/cluster_periph_pkg.sv ====
/*
 * Cluster peripheral package
 * Address map, bus widths, register offsets and the event bit
 * layout shared by the decoder, the peripherals and the top level
 */
package cluster_periph_pkg;

  // APB window seen by the cluster peripherals
  localparam int unsigned APB_ADDR_W = 12;
  localparam int unsigned APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // Page field picks one of the peripherals
  localparam int unsigned PAGE_MSB = 11;
  localparam int unsigned PAGE_LSB = 10;

  typedef enum logic [1:0] {
    PAGE_CTRL  = 2'd0,
    PAGE_TIMER = 2'd1,
    PAGE_EVENT = 2'd2,
    PAGE_NONE  = 2'd3
  } page_e;

  // Control unit, boot address of core k at CTRL_BOOT_OFS + 4k
  localparam apb_addr_t CTRL_EOC_OFS   = 12'h000;
  localparam apb_addr_t CTRL_FETCH_OFS = 12'h004;
  localparam apb_addr_t CTRL_BOOT_OFS  = 12'h040;

  // Timer
  localparam apb_addr_t   TIMER_CFG_OFS     = 12'h000;
  localparam apb_addr_t   TIMER_COUNT_OFS   = 12'h004;
  localparam apb_addr_t   TIMER_CMP_OFS     = 12'h008;
  localparam int unsigned TIMER_CFG_EN_BIT  = 0;
  localparam int unsigned TIMER_CFG_CLR_BIT = 1;

  // Event unit, mask and buffer repeat every 8 bytes per core
  localparam apb_addr_t EVT_MASK_OFS    = 12'h000;
  localparam apb_addr_t EVT_BUF_OFS     = 12'h004;
  localparam apb_addr_t EVT_SW_TRIG_OFS = 12'h040;

  localparam int unsigned EVT_W = 7;
  typedef logic [EVT_W-1:0] evt_vec_t;

  localparam int unsigned EVT_TIMER_BIT = 0;
  localparam int unsigned EVT_DMA_BIT   = 1;
  localparam int unsigned EVT_ACC_LSB   = 2;
  localparam int unsigned EVT_SW_BIT    = 6;

  localparam int unsigned ACC_EVT_W = 4;
  typedef logic [ACC_EVT_W-1:0] acc_evt_t;

  typedef logic [31:0] boot_addr_t;
  localparam boot_addr_t DEFAULT_BOOT_ADDR = 32'h1C00_0000;

endpackage

// ==== src/periph_apb_if.sv ====
/*
 * Peripheral APB link
 * Zero wait state APB between the address decoder and one
 * peripheral, paddr carries the offset inside the page only
 */
`timescale 1ns/100ps

interface periph_apb_if import cluster_periph_pkg::*; ();

  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;

  // Decoder side
  modport master (
    output psel,
    output penable,
    output pwrite,
    output paddr,
    output pwdata,
    input  prdata,
    input  pready
  );

  // Peripheral side
  modport slave (
    input  psel,
    input  penable,
    input  pwrite,
    input  paddr,
    input  pwdata,
    output prdata,
    output pready
  );

endinterface

// ==== src/periph_apb_decoder.sv ====
/*
 * Peripheral APB decoder
 * Splits the cluster peripheral window into pages, forwards each
 * transfer to one peripheral and returns its response
 */
`timescale 1ns/100ps

module periph_apb_decoder import cluster_periph_pkg::*; (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  apb_addr_t        paddr_i,
  input  apb_data_t        pwdata_i,
  output apb_data_t        prdata_o,
  output logic             pready_o,
  output logic             pslverr_o,
  periph_apb_if.master     ctrl_bus,
  periph_apb_if.master     timer_bus,
  periph_apb_if.master     evt_bus
);

  page_e     page;
  apb_addr_t page_ofs;

  assign page     = page_e'(paddr_i[PAGE_MSB:PAGE_LSB]);
  assign page_ofs = {{(APB_ADDR_W-PAGE_LSB){1'b0}}, paddr_i[PAGE_LSB-1:0]};

  //************************************************************
  // Request side
  //************************************************************
  assign ctrl_bus.psel    = psel_i && (page == PAGE_CTRL);
  assign ctrl_bus.penable = penable_i && (page == PAGE_CTRL);
  assign ctrl_bus.pwrite  = pwrite_i;
  assign ctrl_bus.paddr   = page_ofs;
  assign ctrl_bus.pwdata  = pwdata_i;

  assign timer_bus.psel    = psel_i && (page == PAGE_TIMER);
  assign timer_bus.penable = penable_i && (page == PAGE_TIMER);
  assign timer_bus.pwrite  = pwrite_i;
  assign timer_bus.paddr   = page_ofs;
  assign timer_bus.pwdata  = pwdata_i;

  assign evt_bus.psel    = psel_i && (page == PAGE_EVENT);
  assign evt_bus.penable = penable_i && (page == PAGE_EVENT);
  assign evt_bus.pwrite  = pwrite_i;
  assign evt_bus.paddr   = page_ofs;
  assign evt_bus.pwdata  = pwdata_i;

  //************************************************************
  // Response side
  //************************************************************
  always_comb begin
    prdata_o = '0;
    pready_o = 1'b1;
    case (page)
      PAGE_CTRL: begin
        prdata_o = ctrl_bus.prdata;
        pready_o = ctrl_bus.pready;
      end
      PAGE_TIMER: begin
        prdata_o = timer_bus.prdata;
        pready_o = timer_bus.pready;
      end
      PAGE_EVENT: begin
        prdata_o = evt_bus.prdata;
        pready_o = evt_bus.pready;
      end
      default: begin
        // Empty page answers at once with zero data
        prdata_o = '0;
        pready_o = 1'b1;
      end
    endcase
  end

  assign pslverr_o = psel_i && penable_i && (page == PAGE_NONE);

  one_slave_sel_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({ctrl_bus.psel, timer_bus.psel, evt_bus.psel}));

  penable_in_sel_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    penable_i |-> psel_i);

endmodule

// ==== src/cluster_ctrl_unit.sv ====
/*
 * Cluster control unit
 * End-of-computation flag, per-core fetch enable and per-core
 * boot addresses, all read and written over APB
 */
`timescale 1ns/100ps

module cluster_ctrl_unit import cluster_periph_pkg::*; #(
  parameter int unsigned NB_CORES  = 4,
  parameter boot_addr_t  BOOT_ADDR = DEFAULT_BOOT_ADDR
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         fetch_en_i,
  periph_apb_if.slave                  bus,
  output logic                         eoc_o,
  output logic       [NB_CORES-1:0]    core_fetch_en_o,
  output boot_addr_t [NB_CORES-1:0]    boot_addr_o
);

  logic                      eoc_q;
  logic       [NB_CORES-1:0] fetch_en_q;
  boot_addr_t [NB_CORES-1:0] boot_addr_q;
  logic       [NB_CORES-1:0] boot_hit;
  logic                      wr_en;
  apb_data_t                 rdata;

  // Transfer completes in the access cycle, no wait states
  assign wr_en      = bus.psel && bus.penable && bus.pwrite;
  assign bus.pready = 1'b1;

  // One boot address word per core
  always_comb begin
    for (int k = 0; k < NB_CORES; k++) begin
      boot_hit[k] = (bus.paddr == CTRL_BOOT_OFS + apb_addr_t'(4 * k));
    end
  end

  //************************************************************
  // Registers
  //************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= {NB_CORES{BOOT_ADDR}};
    end else if (wr_en) begin
      if (bus.paddr == CTRL_EOC_OFS) begin
        eoc_q <= bus.pwdata[0];
      end
      if (bus.paddr == CTRL_FETCH_OFS) begin
        fetch_en_q <= bus.pwdata[NB_CORES-1:0];
      end
      for (int k = 0; k < NB_CORES; k++) begin
        if (boot_hit[k]) begin
          boot_addr_q[k] <= bus.pwdata;
        end
      end
    end
  end

  //************************************************************
  // Read back
  //************************************************************
  always_comb begin
    rdata = '0;
    if (bus.paddr == CTRL_EOC_OFS) begin
      rdata[0] = eoc_q;
    end
    if (bus.paddr == CTRL_FETCH_OFS) begin
      rdata[NB_CORES-1:0] = fetch_en_q;
    end
    for (int k = 0; k < NB_CORES; k++) begin
      if (boot_hit[k]) begin
        rdata = boot_addr_q[k];
      end
    end
  end

  assign bus.prdata = rdata;

  // External fetch enable starts every core
  assign eoc_o           = eoc_q;
  assign core_fetch_en_o = fetch_en_q | {NB_CORES{fetch_en_i}};
  assign boot_addr_o     = boot_addr_q;

endmodule

// ==== src/cluster_timer.sv ====
/*
 * Cluster timer
 * 32-bit up-counter with compare, emits a one-cycle match event
 * and can restart from zero on a match
 */
`timescale 1ns/100ps

module cluster_timer import cluster_periph_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  periph_apb_if.slave bus,
  output logic        match_evt_o
);

  logic [1:0] cfg_q;
  apb_data_t  count_q;
  apb_data_t  cmp_q;
  logic       match_evt_q;
  logic       wr_en;
  logic       count_en;
  logic       match_hit;
  apb_data_t  rdata;

  assign wr_en      = bus.psel && bus.penable && bus.pwrite;
  assign bus.pready = 1'b1;

  assign count_en = cfg_q[TIMER_CFG_EN_BIT];

  // Compare hit, held off for one cycle after a match
  assign match_hit = count_en && (count_q == cmp_q) && !match_evt_q;

  //************************************************************
  // Configuration and compare
  //************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
      cmp_q <= '0;
    end else if (wr_en) begin
      if (bus.paddr == TIMER_CFG_OFS) begin
        cfg_q <= bus.pwdata[1:0];
      end
      if (bus.paddr == TIMER_CMP_OFS) begin
        cmp_q <= bus.pwdata;
      end
    end
  end

  //************************************************************
  // Counter and match event
  //************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q     <= '0;
      match_evt_q <= 1'b0;
    end else begin
      match_evt_q <= match_hit;
      // Software write has priority over counting
      if (wr_en && (bus.paddr == TIMER_COUNT_OFS)) begin
        count_q <= bus.pwdata;
      end else if (match_hit && cfg_q[TIMER_CFG_CLR_BIT]) begin
        count_q <= '0;
      end else if (count_en) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (bus.paddr)
      TIMER_CFG_OFS:   rdata[1:0] = cfg_q;
      TIMER_COUNT_OFS: rdata = count_q;
      TIMER_CMP_OFS:   rdata = cmp_q;
      default:         rdata = '0;
    endcase
  end

  assign bus.prdata  = rdata;
  assign match_evt_o = match_evt_q;

  match_single_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    match_evt_o |=> !match_evt_o);

endmodule

// ==== src/cluster_event_unit.sv ====
/*
 * Cluster event unit
 * Sticky per-core event buffers with masks, a software trigger
 * and one registered interrupt request per core
 */
`timescale 1ns/100ps

module cluster_event_unit import cluster_periph_pkg::*; #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    timer_evt_i,
  input  logic     [NB_CORES-1:0] dma_event_i,
  input  acc_evt_t [NB_CORES-1:0] acc_events_i,
  periph_apb_if.slave             bus,
  output logic     [NB_CORES-1:0] irq_req_o
);

  // Byte distance between the register pairs of two cores
  localparam int unsigned EVT_STRIDE = 8;

  evt_vec_t [NB_CORES-1:0] evt_mask_q;
  evt_vec_t [NB_CORES-1:0] evt_buf_q;
  evt_vec_t [NB_CORES-1:0] evt_buf_d;
  evt_vec_t [NB_CORES-1:0] evt_in;
  evt_vec_t [NB_CORES-1:0] buf_clr;
  logic     [NB_CORES-1:0] mask_hit;
  logic     [NB_CORES-1:0] buf_hit;
  logic     [NB_CORES-1:0] irq_req_q;
  logic                    wr_en;
  logic                    sw_wr;
  apb_data_t               rdata;

  assign wr_en      = bus.psel && bus.penable && bus.pwrite;
  assign sw_wr      = wr_en && (bus.paddr == EVT_SW_TRIG_OFS);
  assign bus.pready = 1'b1;

  //************************************************************
  // Event assembly and buffer update
  //************************************************************
  always_comb begin
    for (int k = 0; k < NB_CORES; k++) begin
      mask_hit[k] = (bus.paddr == EVT_MASK_OFS + apb_addr_t'(EVT_STRIDE * k));
      buf_hit[k]  = (bus.paddr == EVT_BUF_OFS + apb_addr_t'(EVT_STRIDE * k));

      evt_in[k]                           = '0;
      evt_in[k][EVT_TIMER_BIT]            = timer_evt_i;
      evt_in[k][EVT_DMA_BIT]              = dma_event_i[k];
      evt_in[k][EVT_ACC_LSB +: ACC_EVT_W] = acc_events_i[k];
      evt_in[k][EVT_SW_BIT]               = sw_wr && bus.pwdata[k];

      // Write of ones clears, a new event in the same cycle wins
      buf_clr[k]   = (wr_en && buf_hit[k]) ? bus.pwdata[EVT_W-1:0] : '0;
      evt_buf_d[k] = (evt_buf_q[k] & ~buf_clr[k]) | evt_in[k];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      evt_mask_q <= '0;
      evt_buf_q  <= '0;
      irq_req_q  <= '0;
    end else begin
      evt_buf_q <= evt_buf_d;
      for (int k = 0; k < NB_CORES; k++) begin
        if (wr_en && mask_hit[k]) begin
          evt_mask_q[k] <= bus.pwdata[EVT_W-1:0];
        end
        irq_req_q[k] <= |(evt_buf_q[k] & evt_mask_q[k]);
      end
    end
  end

  //************************************************************
  // Read back, the software trigger reads as zero
  //************************************************************
  always_comb begin
    rdata = '0;
    for (int k = 0; k < NB_CORES; k++) begin
      if (mask_hit[k]) begin
        rdata[EVT_W-1:0] = evt_mask_q[k];
      end
      if (buf_hit[k]) begin
        rdata[EVT_W-1:0] = evt_buf_q[k];
      end
    end
  end

  assign bus.prdata = rdata;
  assign irq_req_o  = irq_req_q;

  for (genvar k = 0; k < NB_CORES; k++) begin : gen_irq_chk
    irq_needs_mask_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      irq_req_o[k] |-> ($past(evt_mask_q[k]) != '0));
  end

endmodule

// ==== src/cluster_peripherals.sv ====
/*
 * Cluster peripheral subsystem
 * APB slave port feeding the control unit, the cluster timer
 * and the event unit through a page decoder
 */
`timescale 1ns/100ps

module cluster_peripherals import cluster_periph_pkg::*; #(
  parameter int unsigned NB_CORES  = 4,
  parameter boot_addr_t  BOOT_ADDR = DEFAULT_BOOT_ADDR
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      fetch_en_i,

  // APB slave port
  input  logic                      apb_psel_i,
  input  logic                      apb_penable_i,
  input  logic                      apb_pwrite_i,
  input  apb_addr_t                 apb_paddr_i,
  input  apb_data_t                 apb_pwdata_i,
  output apb_data_t                 apb_prdata_o,
  output logic                      apb_pready_o,
  output logic                      apb_pslverr_o,

  // Per-core events and controls
  input  logic       [NB_CORES-1:0] dma_event_i,
  input  acc_evt_t   [NB_CORES-1:0] acc_events_i,
  output logic                      eoc_o,
  output logic       [NB_CORES-1:0] core_fetch_en_o,
  output boot_addr_t [NB_CORES-1:0] boot_addr_o,
  output logic       [NB_CORES-1:0] irq_req_o
);

  if ((NB_CORES < 1) || (NB_CORES > 8)) begin : gen_cores_chk
    $error("NB_CORES must lie between 1 and 8");
  end

  logic s_timer_evt;

  periph_apb_if ctrl_bus ();
  periph_apb_if timer_bus ();
  periph_apb_if evt_bus ();

  //************************************************************
  // Address decoder
  //************************************************************
  periph_apb_decoder periph_apb_decoder_i (
    .clk_i     ( clk_i         ),
    .arst_n_i  ( arst_n_i      ),
    .psel_i    ( apb_psel_i    ),
    .penable_i ( apb_penable_i ),
    .pwrite_i  ( apb_pwrite_i  ),
    .paddr_i   ( apb_paddr_i   ),
    .pwdata_i  ( apb_pwdata_i  ),
    .prdata_o  ( apb_prdata_o  ),
    .pready_o  ( apb_pready_o  ),
    .pslverr_o ( apb_pslverr_o ),
    .ctrl_bus  ( ctrl_bus      ),
    .timer_bus ( timer_bus     ),
    .evt_bus   ( evt_bus       )
  );

  //************************************************************
  // Peripherals
  //************************************************************
  cluster_ctrl_unit #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) cluster_ctrl_unit_i (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .fetch_en_i      ( fetch_en_i      ),
    .bus             ( ctrl_bus        ),
    .eoc_o           ( eoc_o           ),
    .core_fetch_en_o ( core_fetch_en_o ),
    .boot_addr_o     ( boot_addr_o     )
  );

  cluster_timer cluster_timer_i (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .bus         ( timer_bus   ),
    .match_evt_o ( s_timer_evt )
  );

  cluster_event_unit #(
    .NB_CORES ( NB_CORES )
  ) cluster_event_unit_i (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .timer_evt_i  ( s_timer_evt  ),
    .dma_event_i  ( dma_event_i  ),
    .acc_events_i ( acc_events_i ),
    .bus          ( evt_bus      ),
    .irq_req_o    ( irq_req_o    )
  );

endmodule

// ==== test/tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 * Free running clock and an active low reset held for a few cycles
 */
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after a rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

// ==== test/tb_cluster_peripherals.sv ====
/*
 * Cluster peripheral testbench
 * Drives the APB port and the event inputs and checks the control unit,
 * the timer and the event unit with assertions
 */
`timescale 1ns/100ps

module tb_cluster_peripherals import cluster_periph_pkg::*; ();

  localparam int unsigned NB_CORES      = 4;
  localparam boot_addr_t  BOOT_ADDR     = DEFAULT_BOOT_ADDR;
  localparam int unsigned SEED          = 88031;
  localparam int unsigned TIMER_CMP_MAX = 40;

  // Cycle budget of each test
  // A transfer with its idle cycle takes 3
  localparam int unsigned RESET_LEN  = 10;
  localparam int unsigned BOOT_LEN   = 6 * NB_CORES + 4;
  localparam int unsigned CTRL_LEN   = 24;
  localparam int unsigned APB_LEN    = 12;
  localparam int unsigned TIMER_LEN  = 3 * TIMER_CMP_MAX + 30;
  localparam int unsigned IRQ_LEN    = 40;
  localparam int unsigned SW_LEN     = 6 * NB_CORES + 6;
  localparam int unsigned WATCHDOG_CYCLES =
    2 * (RESET_LEN + BOOT_LEN + CTRL_LEN + APB_LEN + TIMER_LEN + IRQ_LEN + SW_LEN) + 1000;

  localparam apb_addr_t CTRL_BASE  = apb_addr_t'(PAGE_CTRL) << PAGE_LSB;
  localparam apb_addr_t TIMER_BASE = apb_addr_t'(PAGE_TIMER) << PAGE_LSB;
  localparam apb_addr_t EVT_BASE   = apb_addr_t'(PAGE_EVENT) << PAGE_LSB;
  localparam apb_addr_t NONE_BASE  = apb_addr_t'(PAGE_NONE) << PAGE_LSB;

  logic                      clk;
  logic                      arst_n;
  logic                      fetch_en;
  logic                      apb_psel;
  logic                      apb_penable;
  logic                      apb_pwrite;
  apb_addr_t                 apb_paddr;
  apb_data_t                 apb_pwdata;
  apb_data_t                 apb_prdata;
  logic                      apb_pready;
  logic                      apb_pslverr;
  logic       [NB_CORES-1:0] dma_event;
  acc_evt_t   [NB_CORES-1:0] acc_events;
  logic                      eoc;
  logic       [NB_CORES-1:0] core_fetch_en;
  boot_addr_t [NB_CORES-1:0] boot_addr;
  logic       [NB_CORES-1:0] irq_req;

  int unsigned               errors;
  int unsigned               polls;
  int unsigned               core;
  int unsigned               acc_bit;
  apb_data_t                 rdata;
  logic                      rerr;
  apb_data_t                 cmp;
  apb_addr_t                 mask_addr;
  apb_addr_t                 buf_addr;
  logic       [NB_CORES-1:0] fetch_bits;
  logic       [NB_CORES-1:0] sw_set;
  boot_addr_t [NB_CORES-1:0] boot_exp;
  acc_evt_t   [NB_CORES-1:0] acc_pulse;

  tb_clk_gen #(
    .PERIOD_NS    ( 8 ),
    .RESET_CYCLES ( 2 )
  ) tb_clk_gen_i (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  cluster_peripherals #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) cluster_peripherals_i (
    .clk_i           ( clk           ),
    .arst_n_i        ( arst_n        ),
    .fetch_en_i      ( fetch_en      ),
    .apb_psel_i      ( apb_psel      ),
    .apb_penable_i   ( apb_penable   ),
    .apb_pwrite_i    ( apb_pwrite    ),
    .apb_paddr_i     ( apb_paddr     ),
    .apb_pwdata_i    ( apb_pwdata    ),
    .apb_prdata_o    ( apb_prdata    ),
    .apb_pready_o    ( apb_pready    ),
    .apb_pslverr_o   ( apb_pslverr   ),
    .dma_event_i     ( dma_event     ),
    .acc_events_i    ( acc_events    ),
    .eoc_o           ( eoc           ),
    .core_fetch_en_o ( core_fetch_en ),
    .boot_addr_o     ( boot_addr     ),
    .irq_req_o       ( irq_req       )
  );

  //************************************************************
  // Bus protocol checks
  //************************************************************
  pready_access_a: assert property (@(posedge clk) disable iff (!arst_n)
    (apb_psel && apb_penable) |-> apb_pready)
    else begin
      errors++;
      $display("error at %0t ns: apb_pready_o expected 1, got %0b", $time, apb_pready);
    end

  pslverr_page_a: assert property (@(posedge clk) disable iff (!arst_n)
    apb_pslverr == (apb_psel && apb_penable && (apb_paddr[PAGE_MSB:PAGE_LSB] == PAGE_NONE)))
    else begin
      errors++;
      $display("error at %0t ns: apb_pslverr_o expected %0b, got %0b", $time,
               apb_psel && apb_penable && (apb_paddr[PAGE_MSB:PAGE_LSB] == PAGE_NONE),
               apb_pslverr);
    end

  task automatic check_value(input string name, input apb_data_t expected,
                             input apb_data_t actual);
    assert (actual === expected) else begin
      errors++;
      $display("error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
    end
  endtask

  // Setup cycle then access cycle
  // Inputs move 1 ns after each edge
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge clk);
    #1;
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b1;
    apb_paddr   = addr;
    apb_pwdata  = data;
    @(posedge clk);
    #1;
    apb_penable = 1'b1;
    @(posedge clk);
    #1;
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(posedge clk);
    #1;
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
    apb_paddr   = addr;
    @(posedge clk);
    #1;
    apb_penable = 1'b1;
    // Mid access cycle
    #3;
    data = apb_prdata;
    err  = apb_pslverr;
    @(posedge clk);
    #1;
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
  endtask

  // One cycle pulse on the event inputs
  task automatic pulse_events(input logic [NB_CORES-1:0] dma, input acc_evt_t [NB_CORES-1:0] acc);
    @(posedge clk);
    #1;
    dma_event  = dma;
    acc_events = acc;
    @(posedge clk);
    #1;
    dma_event  = '0;
    acc_events = '0;
  endtask

  //************************************************************
  // Test sequence
  //************************************************************
  initial begin
    errors      = 0;
    fetch_en    = 1'b0;
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
    apb_paddr   = '0;
    apb_pwdata  = '0;
    dma_event   = '0;
    acc_events  = '0;
    void'($urandom(SEED));
    @(posedge arst_n);
    #1;

    // Reset values and boot addresses
    check_value("eoc_o", '0, eoc);
    check_value("core_fetch_en_o", '0, core_fetch_en);
    check_value("irq_req_o", '0, irq_req);
    for (int k = 0; k < NB_CORES; k++) begin
      check_value($sformatf("boot_addr_o[%0d]", k), BOOT_ADDR, boot_addr[k]);
      boot_exp[k] = $urandom;
      apb_write(CTRL_BASE + CTRL_BOOT_OFS + apb_addr_t'(4 * k), boot_exp[k]);
      check_value($sformatf("boot_addr_o[%0d]", k), boot_exp[k], boot_addr[k]);
    end
    for (int k = 0; k < NB_CORES; k++) begin
      apb_read(CTRL_BASE + CTRL_BOOT_OFS + apb_addr_t'(4 * k), rdata, rerr);
      check_value($sformatf("prdata boot %0d", k), boot_exp[k], rdata);
    end

    // End of computation and fetch enable
    apb_write(CTRL_BASE + CTRL_EOC_OFS, 32'h1);
    check_value("eoc_o", 32'h1, eoc);
    apb_read(CTRL_BASE + CTRL_EOC_OFS, rdata, rerr);
    check_value("prdata eoc", 32'h1, rdata);
    fetch_bits = NB_CORES'($urandom_range(2 ** NB_CORES - 2, 1));
    apb_write(CTRL_BASE + CTRL_FETCH_OFS, apb_data_t'(fetch_bits));
    check_value("core_fetch_en_o", apb_data_t'(fetch_bits), core_fetch_en);
    @(posedge clk);
    #1 fetch_en = 1'b1;
    @(posedge clk);
    #1;
    check_value("core_fetch_en_o", apb_data_t'({NB_CORES{1'b1}}), core_fetch_en);
    fetch_en = 1'b0;
    @(posedge clk);
    #1;
    check_value("core_fetch_en_o", apb_data_t'(fetch_bits), core_fetch_en);

    // Empty page and unmapped offsets
    apb_read(NONE_BASE + apb_addr_t'(4 * $urandom_range(255, 0)), rdata, rerr);
    check_value("pslverr empty page", 32'h1, apb_data_t'(rerr));
    check_value("prdata empty page", '0, rdata);
    apb_read(CTRL_BASE + 12'h010, rdata, rerr);
    check_value("pslverr unmapped", '0, apb_data_t'(rerr));
    check_value("prdata unmapped", '0, rdata);

    // Timer match with clear on match
    cmp = $urandom_range(TIMER_CMP_MAX, 16);
    apb_write(TIMER_BASE + TIMER_CMP_OFS, cmp);
    apb_write(TIMER_BASE + TIMER_COUNT_OFS, '0);
    apb_write(TIMER_BASE + TIMER_CFG_OFS, (1 << TIMER_CFG_EN_BIT) | (1 << TIMER_CFG_CLR_BIT));
    polls = 0;
    rdata = '0;
    while (!rdata[EVT_TIMER_BIT] && (polls < TIMER_CMP_MAX)) begin
      apb_read(EVT_BASE + EVT_BUF_OFS, rdata, rerr);
      polls++;
    end
    timer_evt_seen_a: assert (rdata[EVT_TIMER_BIT]) else begin
      errors++;
      $display("timer match never set the timer bit in the event buffer of core 0");
    end
    repeat (4) begin
      apb_read(TIMER_BASE + TIMER_COUNT_OFS, rdata, rerr);
      count_bound_a: assert (rdata <= cmp) else begin
        errors++;
        $display("error at %0t ns: timer count expected at most %0d, got %0d", $time, cmp, rdata);
      end
    end
    apb_write(TIMER_BASE + TIMER_CFG_OFS, '0);

    // Interrupt masking on one core
    core      = $urandom_range(NB_CORES - 1, 0);
    acc_bit   = $urandom_range(ACC_EVT_W - 1, 0);
    mask_addr = EVT_BASE + EVT_MASK_OFS + apb_addr_t'(8 * core);
    buf_addr  = EVT_BASE + EVT_BUF_OFS + apb_addr_t'(8 * core);
    apb_write(buf_addr, 32'h7F);
    apb_write(mask_addr, 1 << EVT_DMA_BIT);
    apb_read(mask_addr, rdata, rerr);
    check_value("prdata mask", 1 << EVT_DMA_BIT, rdata);
    acc_pulse                = '0;
    acc_pulse[core][acc_bit] = 1'b1;
    pulse_events('0, acc_pulse);
    apb_read(buf_addr, rdata, rerr);
    check_value("prdata buffer acc", 1 << (EVT_ACC_LSB + acc_bit), rdata);
    check_value("irq_req_o unmasked", '0, apb_data_t'(irq_req[core]));
    pulse_events(NB_CORES'(1) << core, '0);
    check_value("irq_req_o same cycle", '0, apb_data_t'(irq_req[core]));
    @(posedge clk);
    #1;
    check_value("irq_req_o masked", 32'h1, apb_data_t'(irq_req[core]));
    apb_write(buf_addr, 32'h7F);
    check_value("irq_req_o before clear", 32'h1, apb_data_t'(irq_req[core]));
    @(posedge clk);
    #1;
    check_value("irq_req_o after clear", '0, apb_data_t'(irq_req[core]));
    apb_write(mask_addr, '0);

    // Software trigger
    for (int k = 0; k < NB_CORES; k++) begin
      apb_write(EVT_BASE + EVT_BUF_OFS + apb_addr_t'(8 * k), 32'h7F);
    end
    sw_set = NB_CORES'($urandom_range(2 ** NB_CORES - 1, 1));
    apb_write(EVT_BASE + EVT_SW_TRIG_OFS, apb_data_t'(sw_set));
    for (int k = 0; k < NB_CORES; k++) begin
      apb_read(EVT_BASE + EVT_BUF_OFS + apb_addr_t'(8 * k), rdata, rerr);
      check_value($sformatf("prdata buffer %0d", k),
                  sw_set[k] ? apb_data_t'(1 << EVT_SW_BIT) : '0, rdata);
    end

    repeat (2) @(posedge clk);
    $display("run complete, errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, errors: %0d", WATCHDOG_CYCLES, errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== cluster_peripherals.f ====
src/cluster_periph_pkg.sv
src/periph_apb_if.sv
src/periph_apb_decoder.sv
src/cluster_ctrl_unit.sv
src/cluster_timer.sv
src/cluster_event_unit.sv
src/cluster_peripherals.sv
test/tb_clk_gen.sv
test/tb_cluster_peripherals.sv

// ==== Bender.yml ====
package:
  name: cluster_peripherals

sources:
  # RTL in compile order
  - files:
      - src/cluster_periph_pkg.sv
      - src/periph_apb_if.sv
      - src/periph_apb_decoder.sv
      - src/cluster_ctrl_unit.sv
      - src/cluster_timer.sv
      - src/cluster_event_unit.sv
      - src/cluster_peripherals.sv

  # Testbench
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_cluster_peripherals.sv
